//--- trails_defines.svh
// sizes for the trail subsystem
// coordinates are 5 bits and wrap, so the grid is always 32 by 32 cells
`ifndef TRAILS_DEFINES_SVH
`define TRAILS_DEFINES_SVH

// playfield
`define GRID_BITS 5
`define GRID_SIZE 32

// tiles, four words each
`define TILE_WORDS 4
`define TILE_WORD_BITS 2

// frame buffer port
`define FB_ADDR_W 12
`define FB_DATA_W 16

// register bus
`define APB_ADDR_W 8

`endif

//--- design/trail_pkg.sv
// types shared by the trail blocks
// tile kind codes are stored in the ROM words, so their values are fixed
`default_nettype none

`include "trails_defines.svh"

package trail_pkg;

	typedef logic [`GRID_BITS-1:0] coord_t;
	// 0 up, 1 down, 2 left, 3 right
	typedef logic [1:0] dir_t;
	typedef logic [`FB_ADDR_W-1:0] fb_addr_t;
	typedef logic [`FB_DATA_W-1:0] fb_data_t;
	typedef logic [`TILE_WORD_BITS-1:0] word_idx_t;

	typedef enum logic [2:0]
	{
		NONE    = 3'd0,
		B_HORIZ = 3'd1,
		B_VERT  = 3'd2,
		R_HORIZ = 3'd3,
		R_VERT  = 3'd4,
		CORNER  = 3'd5
	} tile_kind_e;

	typedef struct packed
	{
		coord_t x;
		coord_t y;
		dir_t dir;
	} player_pos_t;

	typedef struct packed
	{
		logic valid;
		tile_kind_e kind;
		coord_t x;
		coord_t y;
	} trail_req_t;

	typedef struct packed
	{
		logic we;
		fb_addr_t addr;
		fb_data_t data;
	} fb_wr_t;

	typedef struct packed
	{
		tile_kind_e kind;
		word_idx_t word;
	} rom_addr_t;

	typedef enum logic [1:0]
	{
		IDLE,
		READ,
		DRAIN,
		ACK
	} blit_state_e;

endpackage

`default_nettype wire

//--- design/trail_tile_rom.sv
// tile words, one cycle read latency
// word layout is kind code, word index, pattern byte; unknown kinds read as zero
`timescale 1ns/10ps
`default_nettype none

module trail_tile_rom
(
	input wire logic Clk,
	input trail_pkg::rom_addr_t rom_addr,
	output trail_pkg::fb_data_t rom_data
);

	import trail_pkg::*;

	logic [7:0] pattern;
	logic valid_kind;
	logic [3:0] kind_code;
	logic [3:0] word_code;

	assign kind_code = 4'(rom_addr.kind);
	assign word_code = 4'(rom_addr.word);

	// pattern byte per kind
	always_comb
	begin
		valid_kind = 1'b1;
		pattern = 8'h00;
		case (rom_addr.kind)
			B_HORIZ, R_HORIZ:
				pattern = 8'hFF;
			B_VERT, R_VERT:
				pattern = 8'h3C;
			CORNER:
				pattern = 8'h81;
			default:
				valid_kind = 1'b0;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (valid_kind)
			rom_data <= {kind_code, word_code, pattern};
		else
			rom_data <= '0;
	end

endmodule

`default_nettype wire

//--- design/trail_classifier.sv
// picks the tile for the cell a cycle has just left
// the first move after run rises only primes the previous position
`timescale 1ns/10ps
`default_nettype none

`include "trails_defines.svh"

module trail_classifier
#(
	parameter bit RED = 1'b0
)
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic run,
	input wire logic clearing,
	input wire logic move_strobe,
	input trail_pkg::player_pos_t pos,
	input wire logic ack,
	output trail_pkg::trail_req_t req
);

	import trail_pkg::*;

	localparam tile_kind_e HORIZ_KIND = tile_kind_e'(RED ? R_HORIZ : B_HORIZ);
	localparam tile_kind_e VERT_KIND = tile_kind_e'(RED ? R_VERT : B_VERT);

	player_pos_t prev_pos;
	logic primed;
	logic cell_changed;
	tile_kind_e next_kind;

	logic req_valid;
	tile_kind_e req_kind;
	coord_t req_x;
	coord_t req_y;

	assign cell_changed = (pos.x != prev_pos.x) || (pos.y != prev_pos.y);

	always_comb
	begin
		if (pos.dir != prev_pos.dir)
			next_kind = CORNER;
		// up and down have bit 1 clear
		else if (!pos.dir[1])
			next_kind = VERT_KIND;
		else
			next_kind = HORIZ_KIND;
	end

	// control state
	always_ff @(posedge Clk)
	begin
		if (rst || !run)
		begin
			primed <= 1'b0;
			req_valid <= 1'b0;
		end
		else
		begin
			if (ack)
				req_valid <= 1'b0;
			if (move_strobe && !clearing)
			begin
				primed <= 1'b1;
				if (primed && cell_changed)
					req_valid <= 1'b1;
			end
		end
	end

	// payload, a newer move overwrites a pending one
	always_ff @(posedge Clk)
	begin
		if (move_strobe && !clearing)
		begin
			prev_pos <= pos;
			if (primed && cell_changed)
			begin
				req_kind <= next_kind;
				req_x <= prev_pos.x;
				req_y <= prev_pos.y;
			end
		end
	end

	assign req = '{valid: req_valid, kind: req_kind, x: req_x, y: req_y};

endmodule

`default_nettype wire

//--- design/trail_blitter.sv
// copies tile words from the ROM into the frame buffer, blue before red
// one tile takes about seven cycles; the frame buffer never stalls
`timescale 1ns/10ps
`default_nettype none

`include "trails_defines.svh"

module trail_blitter
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic run,
	input trail_pkg::trail_req_t blue_req,
	input trail_pkg::trail_req_t red_req,
	output logic blue_ack,
	output logic red_ack,
	output trail_pkg::rom_addr_t rom_addr,
	input trail_pkg::fb_data_t rom_data,
	output trail_pkg::fb_wr_t fb_wr,
	output logic tile_done
);

	import trail_pkg::*;

	localparam word_idx_t LAST_WORD = word_idx_t'(`TILE_WORDS - 1);

	blit_state_e state;
	logic sel_red;
	word_idx_t word;

	// tile being copied
	tile_kind_e cur_kind;
	coord_t cur_x;
	coord_t cur_y;
	fb_addr_t tile_base;

	// write stage, lines up with the ROM output
	logic wr_we;
	fb_addr_t wr_addr;

	// cell index times four
	assign tile_base = fb_addr_t'({cur_y, cur_x, {`TILE_WORD_BITS{1'b0}}});

	assign rom_addr = '{kind: cur_kind, word: word};

	always_ff @(posedge Clk)
	begin
		if (rst || !run)
		begin
			state <= IDLE;
			sel_red <= 1'b0;
			word <= '0;
			wr_we <= 1'b0;
		end
		else
		begin
			wr_we <= 1'b0;
			case (state)
				IDLE:
				begin
					word <= '0;
					if (blue_req.valid)
					begin
						sel_red <= 1'b0;
						state <= READ;
					end
					else if (red_req.valid)
					begin
						sel_red <= 1'b1;
						state <= READ;
					end
				end
				READ:
				begin
					// one ROM read per cycle
					wr_we <= 1'b1;
					word <= word + 1'b1;
					if (word == LAST_WORD)
						state <= DRAIN;
				end
				DRAIN:
					state <= ACK;
				ACK:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// request payload, taken when a tile starts
	always_ff @(posedge Clk)
	begin
		if (state == IDLE)
		begin
			if (blue_req.valid)
			begin
				cur_kind <= blue_req.kind;
				cur_x <= blue_req.x;
				cur_y <= blue_req.y;
			end
			else
			begin
				cur_kind <= red_req.kind;
				cur_x <= red_req.x;
				cur_y <= red_req.y;
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		if (state == READ)
			wr_addr <= tile_base + fb_addr_t'(word);
	end

	assign fb_wr = '{we: wr_we, addr: wr_addr, data: rom_data};

	assign tile_done = (state == ACK);
	assign blue_ack = (state == ACK) && !sel_red;
	assign red_ack = (state == ACK) && sel_red;

endmodule

`default_nettype wire

//--- design/trail_occupancy.sv
// bitmap of visited cells and sticky collision flags
// a rising run sweeps one row per cycle; moves are ignored meanwhile
`timescale 1ns/10ps
`default_nettype none

`include "trails_defines.svh"

module trail_occupancy
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic run,
	input wire logic move_strobe,
	input trail_pkg::player_pos_t blue_pos,
	input trail_pkg::player_pos_t red_pos,
	output logic clearing,
	output logic blue_hit,
	output logic red_hit
);

	import trail_pkg::*;

	localparam coord_t LAST_ROW = coord_t'(`GRID_SIZE - 1);

	logic [`GRID_SIZE-1:0] occ [`GRID_SIZE];
	logic run_d;
	logic run_rise;
	coord_t clr_row;

	logic move_ok;
	logic blue_seen;
	logic red_seen;
	logic same_cell;

	assign run_rise = run && !run_d;
	assign move_ok = run && !clearing && move_strobe;

	assign blue_seen = occ[blue_pos.y][blue_pos.x];
	assign red_seen = occ[red_pos.y][red_pos.x];
	assign same_cell = (blue_pos.x == red_pos.x) && (blue_pos.y == red_pos.y);

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			run_d <= 1'b0;
			clearing <= 1'b0;
			clr_row <= '0;
			blue_hit <= 1'b0;
			red_hit <= 1'b0;
		end
		else
		begin
			run_d <= run;
			if (run_rise)
			begin
				clearing <= 1'b1;
				clr_row <= '0;
				blue_hit <= 1'b0;
				red_hit <= 1'b0;
			end
			else if (clearing)
			begin
				clr_row <= clr_row + 1'b1;
				if (clr_row == LAST_ROW)
					clearing <= 1'b0;
			end
			else if (move_ok)
			begin
				// head-on into one cell hits both
				if (blue_seen || same_cell)
					blue_hit <= 1'b1;
				if (red_seen || same_cell)
					red_hit <= 1'b1;
			end
		end
	end

	// bitmap itself
	always_ff @(posedge Clk)
	begin
		if (clearing)
			occ[clr_row] <= '0;
		if (move_ok)
		begin
			occ[blue_pos.y][blue_pos.x] <= 1'b1;
			occ[red_pos.y][red_pos.x] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/trail_apb_regs.sv
// control, status and tile counter registers
// pready is tied high; unmapped offsets answer with pslverr and zero data
`timescale 1ns/10ps
`default_nettype none

`include "trails_defines.svh"

module trail_apb_regs
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`APB_ADDR_W-1:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	input wire logic clearing,
	input wire logic blue_hit,
	input wire logic red_hit,
	input wire logic tile_done
);

	localparam logic [`APB_ADDR_W-1:0] REG_CTRL = 'h0;
	localparam logic [`APB_ADDR_W-1:0] REG_STATUS = 'h4;
	localparam logic [`APB_ADDR_W-1:0] REG_TILE_COUNT = 'h8;

	logic [15:0] tile_count;
	logic wr_en;
	logic addr_err;

	assign wr_en = psel && penable && pwrite;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			run <= 1'b0;
			tile_count <= '0;
		end
		else
		begin
			if (wr_en && paddr == REG_CTRL)
				run <= pwdata[0];
			// a write of any value clears the count
			if (wr_en && paddr == REG_TILE_COUNT)
				tile_count <= '0;
			else if (tile_done)
				tile_count <= tile_count + 1'b1;
		end
	end

	always_comb
	begin
		prdata = '0;
		addr_err = 1'b0;
		case (paddr)
			REG_CTRL:
				prdata = {31'b0, run};
			REG_STATUS:
				prdata = {29'b0, clearing, red_hit, blue_hit};
			REG_TILE_COUNT:
				prdata = {16'b0, tile_count};
			default:
				addr_err = 1'b1;
		endcase
	end

	assign pready = 1'b1;
	assign pslverr = psel && penable && addr_err;

endmodule

`default_nettype wire

//--- design/trail_top.sv
// trail recorder with collision detection
// the frame buffer must take one write per cycle with no back-pressure
`timescale 1ns/10ps
`default_nettype none

`include "trails_defines.svh"

module trail_top
(
	input wire logic Clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`APB_ADDR_W-1:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input trail_pkg::player_pos_t blue_pos,
	input trail_pkg::player_pos_t red_pos,
	input wire logic move_strobe,
	output trail_pkg::fb_wr_t fb_wr
);

	import trail_pkg::*;

	logic run;
	logic clearing;
	logic blue_hit;
	logic red_hit;
	logic tile_done;
	logic blue_ack;
	logic red_ack;
	trail_req_t blue_req;
	trail_req_t red_req;
	rom_addr_t rom_addr;
	fb_data_t rom_data;

	trail_apb_regs u_regs
	(
		.Clk(Clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.run(run), .clearing(clearing),
		.blue_hit(blue_hit), .red_hit(red_hit), .tile_done(tile_done)
	);

	trail_classifier #(.RED(1'b0)) u_blue_cls
	(
		.Clk(Clk), .rst(rst), .run(run), .clearing(clearing),
		.move_strobe(move_strobe), .pos(blue_pos), .ack(blue_ack), .req(blue_req)
	);

	trail_classifier #(.RED(1'b1)) u_red_cls
	(
		.Clk(Clk), .rst(rst), .run(run), .clearing(clearing),
		.move_strobe(move_strobe), .pos(red_pos), .ack(red_ack), .req(red_req)
	);

	trail_blitter u_blitter
	(
		.Clk(Clk), .rst(rst), .run(run),
		.blue_req(blue_req), .red_req(red_req),
		.blue_ack(blue_ack), .red_ack(red_ack),
		.rom_addr(rom_addr), .rom_data(rom_data),
		.fb_wr(fb_wr), .tile_done(tile_done)
	);

	trail_tile_rom u_rom
	(
		.Clk(Clk), .rom_addr(rom_addr), .rom_data(rom_data)
	);

	trail_occupancy u_occ
	(
		.Clk(Clk), .rst(rst), .run(run), .move_strobe(move_strobe),
		.blue_pos(blue_pos), .red_pos(red_pos),
		.clearing(clearing), .blue_hit(blue_hit), .red_hit(red_hit)
	);

endmodule

`default_nettype wire

//--- tb/trail_tb.sv
// directed tests for the trail subsystem with expected tiles from a software model
// every move is followed by 20 idle cycles, so all tiles of a move finish before the next one
`timescale 1ns/10ps
`default_nettype none

`include "trails_defines.svh"

module trail_tb;

	import trail_pkg::*;

	localparam logic [`APB_ADDR_W-1:0] REG_CTRL = 'h0;
	localparam logic [`APB_ADDR_W-1:0] REG_STATUS = 'h4;
	localparam logic [`APB_ADDR_W-1:0] REG_TILE_COUNT = 'h8;
	localparam logic [`APB_ADDR_W-1:0] REG_NONE = 'hC;

	localparam dir_t DIR_UP = 2'd0;
	localparam dir_t DIR_DOWN = 2'd1;
	localparam dir_t DIR_LEFT = 2'd2;
	localparam dir_t DIR_RIGHT = 2'd3;

	logic Clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	player_pos_t blue_pos;
	player_pos_t red_pos;
	logic move_strobe;
	fb_wr_t fb_wr;

	// model state per player with blue at index 0 and red at 1
	player_pos_t mdl_prev [2];
	bit mdl_primed [2];
	trail_req_t exp_tiles [$];
	fb_wr_t wr_log [$];

	logic [31:0] lfsr;
	int errors;
	int checks;
	int test_num;
	int test_base;

	trail_top u_dut
	(
		.Clk(Clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.blue_pos(blue_pos), .red_pos(red_pos),
		.move_strobe(move_strobe), .fb_wr(fb_wr)
	);

	initial Clk = 1'b0;
	always #50 Clk = ~Clk;

	// log frame buffer writes on the falling edge
	always @(negedge Clk)
	begin
		if (fb_wr.we)
			wr_log.push_back(fb_wr);
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic player_pos_t make_pos(input int x, input int y, input dir_t d);
		player_pos_t p;
		p.x = coord_t'(x);
		p.y = coord_t'(y);
		p.dir = d;
		return p;
	endfunction

	// tile kind for a cell that was left
	function automatic tile_kind_e expect_kind(input bit red, input dir_t old_d, input dir_t new_d);
		if (old_d != new_d)
			return CORNER;
		if (new_d == DIR_UP || new_d == DIR_DOWN)
		begin
			if (red)
				return R_VERT;
			return B_VERT;
		end
		if (red)
			return R_HORIZ;
		return B_HORIZ;
	endfunction

	function automatic fb_addr_t expect_addr(input trail_req_t t, input int w);
		int a;
		a = ((int'(t.y) * `GRID_SIZE) + int'(t.x)) * `TILE_WORDS + w;
		return fb_addr_t'(a);
	endfunction

	function automatic fb_data_t expect_data(input trail_req_t t, input int w);
		logic [7:0] pat;
		case (t.kind)
			B_HORIZ, R_HORIZ:
				pat = 8'hFF;
			B_VERT, R_VERT:
				pat = 8'h3C;
			CORNER:
				pat = 8'h81;
			default:
				pat = 8'h00;
		endcase
		return fb_data_t'((int'(t.kind) << 12) | (w << 8) | int'(pat));
	endfunction

	task automatic model_move(input bit red, input player_pos_t p);
		trail_req_t t;
		if (mdl_primed[red] && (p.x != mdl_prev[red].x || p.y != mdl_prev[red].y))
		begin
			t.valid = 1'b1;
			t.kind = expect_kind(red, mdl_prev[red].dir, p.dir);
			t.x = mdl_prev[red].x;
			t.y = mdl_prev[red].y;
			exp_tiles.push_back(t);
		end
		mdl_prev[red] = p;
		mdl_primed[red] = 1'b1;
	endtask

	task automatic check_addr(input string what, input fb_addr_t got, input fb_addr_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("** Error @ %0t: %s address %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input string what, input fb_data_t got, input fb_data_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("** Error @ %0t: %s data %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("** Error @ %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			$display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic err);
		int waited;
		@(posedge Clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge Clk);
		penable <= 1'b1;
		waited = 0;
		@(negedge Clk);
		while (!pready && waited < 10)
		begin
			@(negedge Clk);
			waited++;
		end
		if (!pready)
		begin
			$display("APB write to %h got no pready", addr);
			errors++;
		end
		err = pslverr;
		@(posedge Clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		int waited;
		@(posedge Clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge Clk);
		penable <= 1'b1;
		waited = 0;
		@(negedge Clk);
		while (!pready && waited < 10)
		begin
			@(negedge Clk);
			waited++;
		end
		if (!pready)
		begin
			$display("APB read from %h got no pready", addr);
			errors++;
		end
		data = prdata;
		err = pslverr;
		@(posedge Clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_expect(input string what, input logic [`APB_ADDR_W-1:0] addr,
		input logic [31:0] exp);
		logic [31:0] data;
		logic err;
		apb_read(addr, data, err);
		check_reg(what, data, exp);
		check_flag({what, " pslverr"}, err, 1'b0);
	endtask

	// polls busy until the clear sweep ends
	task automatic wait_sweep_done();
		logic [31:0] st;
		logic err;
		int tries;
		tries = 0;
		apb_read(REG_STATUS, st, err);
		while (st[2] && tries < 30)
		begin
			apb_read(REG_STATUS, st, err);
			tries++;
		end
		if (st[2])
		begin
			$display("clear sweep still busy after %0d status reads", tries);
			errors++;
		end
	endtask

	task automatic start_run(input bit expect_busy);
		logic err;
		apb_write(REG_CTRL, 32'h1, err);
		check_flag("CTRL write pslverr", err, 1'b0);
		mdl_primed[0] = 1'b0;
		mdl_primed[1] = 1'b0;
		if (expect_busy)
			read_expect("STATUS during sweep", REG_STATUS, 32'h4);
		wait_sweep_done();
	endtask

	task automatic stop_run();
		logic err;
		apb_write(REG_CTRL, 32'h0, err);
		check_flag("CTRL write pslverr", err, 1'b0);
		mdl_primed[0] = 1'b0;
		mdl_primed[1] = 1'b0;
	endtask

	task automatic move(input player_pos_t b, input player_pos_t r);
		model_move(1'b0, b);
		model_move(1'b1, r);
		@(posedge Clk);
		blue_pos <= b;
		red_pos <= r;
		move_strobe <= 1'b1;
		@(posedge Clk);
		move_strobe <= 1'b0;
		repeat (20) @(posedge Clk);
	endtask

	task automatic collect_tile(input trail_req_t t);
		fb_wr_t w;
		int waited;
		int i;
		waited = 0;
		while (wr_log.size() < `TILE_WORDS && waited < 40)
		begin
			@(posedge Clk);
			waited++;
		end
		if (wr_log.size() < `TILE_WORDS)
		begin
			$display("tile at (%0d,%0d) did not get four frame buffer writes", t.x, t.y);
			errors++;
			wr_log.delete();
		end
		else
		begin
			for (i = 0; i < `TILE_WORDS; i++)
			begin
				w = wr_log.pop_front();
				check_addr("tile word", w.addr, expect_addr(t, i));
				check_data("tile word", w.data, expect_data(t, i));
			end
		end
	endtask

	task automatic check_tiles();
		trail_req_t t;
		while (exp_tiles.size() > 0)
		begin
			t = exp_tiles.pop_front();
			collect_tile(t);
		end
		if (wr_log.size() > 0)
		begin
			$display("%0d frame buffer writes that no tile explains", wr_log.size());
			errors++;
			wr_log.delete();
		end
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (errors == test_base)
			$display("test %0d %s: ok", test_num, name);
		else
			$display("test %0d %s: %0d errors", test_num, name, errors - test_base);
		test_base = errors;
	endtask

	task automatic test_straight();
		logic err;
		read_expect("CTRL after reset", REG_CTRL, 32'h0);
		start_run(1'b0);
		move(make_pos(5, 5, DIR_RIGHT), make_pos(20, 20, DIR_LEFT));
		move(make_pos(6, 5, DIR_RIGHT), make_pos(20, 20, DIR_LEFT));
		move(make_pos(7, 5, DIR_RIGHT), make_pos(20, 20, DIR_LEFT));
		move(make_pos(8, 5, DIR_RIGHT), make_pos(20, 20, DIR_LEFT));
		check_tiles();
		read_expect("TILE_COUNT", REG_TILE_COUNT, 32'd3);
		// any write clears the counter
		apb_write(REG_TILE_COUNT, 32'h5, err);
		check_flag("TILE_COUNT write pslverr", err, 1'b0);
		read_expect("TILE_COUNT after clear", REG_TILE_COUNT, 32'h0);
		finish_test("straight line");
	endtask

	task automatic test_turn();
		move(make_pos(9, 5, DIR_RIGHT), make_pos(20, 20, DIR_LEFT));
		move(make_pos(9, 4, DIR_UP), make_pos(20, 20, DIR_LEFT));
		move(make_pos(9, 3, DIR_UP), make_pos(20, 20, DIR_LEFT));
		check_tiles();
		finish_test("turn");
	endtask

	task automatic test_both_players();
		move(make_pos(9, 2, DIR_UP), make_pos(19, 20, DIR_LEFT));
		check_tiles();
		finish_test("both players");
	endtask

	task automatic test_collision();
		stop_run();
		start_run(1'b0);
		move(make_pos(2, 10, DIR_RIGHT), make_pos(3, 7, DIR_DOWN));
		move(make_pos(3, 10, DIR_RIGHT), make_pos(3, 8, DIR_DOWN));
		move(make_pos(4, 10, DIR_RIGHT), make_pos(3, 9, DIR_DOWN));
		read_expect("STATUS before collision", REG_STATUS, 32'h0);
		// red runs into the blue trail
		move(make_pos(4, 11, DIR_DOWN), make_pos(3, 10, DIR_DOWN));
		read_expect("STATUS red hit", REG_STATUS, 32'h2);
		move(make_pos(5, 11, DIR_RIGHT), make_pos(3, 11, DIR_DOWN));
		move(make_pos(5, 12, DIR_DOWN), make_pos(3, 12, DIR_DOWN));
		read_expect("STATUS before head-on", REG_STATUS, 32'h2);
		move(make_pos(4, 12, DIR_LEFT), make_pos(4, 12, DIR_RIGHT));
		read_expect("STATUS head-on", REG_STATUS, 32'h3);
		check_tiles();
		finish_test("collision");
	endtask

	task automatic test_clear_restart();
		stop_run();
		start_run(1'b1);
		read_expect("STATUS after sweep", REG_STATUS, 32'h0);
		// same cells as before the sweep
		move(make_pos(2, 10, DIR_RIGHT), make_pos(3, 7, DIR_DOWN));
		move(make_pos(3, 10, DIR_RIGHT), make_pos(3, 8, DIR_DOWN));
		move(make_pos(4, 10, DIR_RIGHT), make_pos(3, 9, DIR_DOWN));
		read_expect("STATUS on old cells", REG_STATUS, 32'h0);
		check_tiles();
		finish_test("clear and restart");
	endtask

	task automatic test_errors_and_walk();
		logic [31:0] data;
		logic [31:0] bits;
		logic err;
		player_pos_t p;
		int i;
		apb_read(REG_NONE, data, err);
		check_flag("pslverr on read of 0xC", err, 1'b1);
		check_reg("read data of 0xC", data, 32'h0);
		apb_write(REG_NONE, 32'h5, err);
		check_flag("pslverr on write of 0xC", err, 1'b1);
		p = mdl_prev[0];
		for (i = 0; i < 20; i++)
		begin
			take_bits(2, bits);
			p.dir = dir_t'(bits[1:0]);
			case (p.dir)
				DIR_UP:
					p.y = p.y - 1'b1;
				DIR_DOWN:
					p.y = p.y + 1'b1;
				DIR_LEFT:
					p.x = p.x - 1'b1;
				default:
					p.x = p.x + 1'b1;
			endcase
			move(p, mdl_prev[1]);
			check_tiles();
		end
		finish_test("APB errors and random walk");
	endtask

	initial
	begin
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		blue_pos = '0;
		red_pos = '0;
		move_strobe = 1'b0;
		lfsr = 32'h0d749ae2;
		errors = 0;
		checks = 0;
		test_num = 0;
		test_base = 0;
		mdl_primed[0] = 1'b0;
		mdl_primed[1] = 1'b0;
		repeat (10) @(posedge Clk);
		rst <= 1'b0;
		@(posedge Clk);

		test_straight();
		test_turn();
		test_both_players();
		test_collision();
		test_clear_restart();
		test_errors_and_walk();

		$display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- trails.f
+incdir+.
design/trail_pkg.sv
design/trail_tile_rom.sv
design/trail_classifier.sv
design/trail_blitter.sv
design/trail_occupancy.sv
design/trail_apb_regs.sv
design/trail_top.sv
tb/trail_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing
TOP = trail_tb
FILELIST = trails.f
SIM = ./obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$($(SIM)); echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir
